// File: source/kicker_rom_consts.svh
/* Region start addresses, PROM start, write FIFO depth
   and word address widths of the scroll and object slots */
`ifndef KICKER_ROM_CONSTS_SVH
`define KICKER_ROM_CONSTS_SVH

// SDRAM byte addresses of each region
// Main code sits below the scroll region
`define SCR_START  22'h00_8000
`define OBJ_START  22'h00_C000
`define PCM_START  22'h01_4000

// Loader byte address of the first PROM byte
// PROM bytes never reach SDRAM
`define PROM_START 25'h001_C000

// Pending SDRAM writes
`define PROG_FIFO_DEPTH 4

// Slot word address widths
// 16 kB of scroll tiles, 32 kB of object sprites
`define SCR_AW 13
`define OBJ_AW 14

`endif

// File: source/kicker_rom_pkg.sv
/* Vector types of the ROM path and the SDRAM sequencer state encoding */
`default_nettype none

package kicker_rom_pkg;

    // Loader side
    typedef logic [7:0]  byte_t;
    typedef logic [24:0] ioctl_addr_t;
    typedef logic [10:0] prom_addr_t;

    // SDRAM side, word addressed
    typedef logic [15:0] word_t;
    typedef logic [21:0] sdram_addr_t;

    // Sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_WRITE,
        SEQ_READ_ACK,
        SEQ_READ_DATA
    } seq_state_t;

endpackage

`default_nettype wire

// File: source/rom_dwnld.sv
/* Download translator: region decode, address swizzle,
   byte mask generation and PROM write routing */
`timescale 1ns/100ps
`default_nettype none
`include "kicker_rom_consts.svh"

module rom_dwnld
    import kicker_rom_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire ioctl_addr_t ioctl_addr,
    input  wire byte_t       ioctl_dout,
    input  wire logic        ioctl_wr,
    output sdram_addr_t      prog_addr,
    output word_t            prog_data,
    output logic [1:0]       prog_mask,
    output logic             push,
    output prom_addr_t       prom_addr,
    output byte_t            prom_data,
    output logic             prom_we
);

    logic [22:0] byte_addr;
    logic [22:0] swz_addr;
    ioctl_addr_t prom_off;
    logic        is_scr;
    logic        is_obj;
    logic        is_prom;

    assign byte_addr = ioctl_addr[22:0];
    assign prom_off  = ioctl_addr - `PROM_START;

    // Region decode
    assign is_prom = ioctl_addr >= `PROM_START;
    assign is_scr  = ioctl_addr[21:0] >= `SCR_START && ioctl_addr[21:0] < `OBJ_START;
    assign is_obj  = ioctl_addr[21:0] >= `OBJ_START && ioctl_addr[21:0] < `PCM_START;

    always_comb begin
        swz_addr = byte_addr;
        // Scroll tiles swap the two bytes of each word
        if (is_scr) begin
            swz_addr[0] = ~byte_addr[0];
        end
        // Object layout, bits 2:0 move up and bits 4:3 drop to the bottom inverted
        if (is_obj) begin
            swz_addr[4:0] = {byte_addr[2:0], ~byte_addr[4], ~byte_addr[3]};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            push    <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            push    <= ioctl_wr && !is_prom;
            prom_we <= ioctl_wr && is_prom;
        end
    end

    // Payload captured on every loader strobe
    always_ff @(posedge clk) begin
        if (ioctl_wr) begin
            prog_addr <= swz_addr[22:1];
            prog_data <= {ioctl_dout, ioctl_dout};
            // Active low, odd bytes go to the upper half
            prog_mask <= swz_addr[0] ? 2'b01 : 2'b10;
            prom_addr <= prom_off[10:0];
            prom_data <= ioctl_dout;
        end
    end

    // Loader has no ready, the write FIFO relies on this spacing
    a_wr_spacing: assert property (
        @(posedge clk) disable iff (!arst_n)
        ioctl_wr |=> !ioctl_wr [*3]
    ) else $error("Loader writes closer than four cycles");

endmodule

`default_nettype wire

// File: source/prog_fifo.sv
/* Write FIFO of pending SDRAM writes: word address, data and byte mask */
`timescale 1ns/100ps
`default_nettype none
`include "kicker_rom_consts.svh"

module prog_fifo
    import kicker_rom_pkg::*;
#(
    parameter int DEPTH = `PROG_FIFO_DEPTH
) (
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic        push,
    input  wire sdram_addr_t din_addr,
    input  wire word_t       din_data,
    input  wire logic [1:0]  din_mask,
    input  wire logic        pop,
    output logic             empty,
    output sdram_addr_t      dout_addr,
    output word_t            dout_data,
    output logic [1:0]       dout_mask
);

    localparam int PW = $clog2(DEPTH);

    sdram_addr_t   addr_mem [DEPTH];
    word_t         data_mem [DEPTH];
    logic [1:0]    mask_mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;
    logic          full;

    assign empty = count == '0;
    assign full  = count == (PW+1)'(DEPTH);

    // Head entry
    assign dout_addr = addr_mem[rd_ptr];
    assign dout_data = data_mem[rd_ptr];
    assign dout_mask = mask_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= din_addr;
            data_mem[wr_ptr] <= din_data;
            mask_mem[wr_ptr] <= din_mask;
        end
    end

    // Pointers wrap on their own, DEPTH is a power of two
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_overflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        push |-> !full || pop
    ) else $error("Push into a full write FIFO");

    a_no_underflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        pop |-> !empty
    ) else $error("Pop from an empty write FIFO");

endmodule

`default_nettype wire

// File: source/sdram_sequencer.sv
/* SDRAM sequencer: drains the write FIFO during download,
   then serves the scroll and object slot reads round-robin */
`timescale 1ns/100ps
`default_nettype none

module sdram_sequencer
    import kicker_rom_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic        downloading,
    // Write FIFO head
    input  wire logic        fifo_empty,
    input  wire sdram_addr_t fifo_addr,
    input  wire word_t       fifo_data,
    input  wire logic [1:0]  fifo_mask,
    output logic             fifo_pop,
    // Read slots
    input  wire logic        scr_rd_req,
    input  wire sdram_addr_t scr_rd_addr,
    input  wire logic        obj_rd_req,
    input  wire sdram_addr_t obj_rd_addr,
    output logic             scr_rd_done,
    output logic             obj_rd_done,
    output word_t            rd_data,
    // SDRAM controller
    output logic             sdram_req,
    output logic             sdram_we,
    output sdram_addr_t      sdram_addr,
    output word_t            sdram_din,
    output logic [1:0]       sdram_mask,
    input  wire logic        sdram_ack,
    input  wire logic        data_rdy,
    input  wire word_t       data_read,
    output logic             dwnld_busy
);

    seq_state_t state;
    logic       last_obj;
    logic       rd_allow;
    logic       pick_obj;

    assign dwnld_busy = downloading || !fifo_empty;
    assign fifo_pop   = state == SEQ_WRITE && sdram_ack;

    // A slot still shows its request while the done pulse is out
    assign rd_allow = !downloading && !scr_rd_done && !obj_rd_done;
    // Object wins unless it was served last and scroll is waiting
    assign pick_obj = obj_rd_req && (!scr_rd_req || !last_obj);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= SEQ_IDLE;
            sdram_req   <= 1'b0;
            sdram_we    <= 1'b0;
            last_obj    <= 1'b0;
            scr_rd_done <= 1'b0;
            obj_rd_done <= 1'b0;
        end else begin
            scr_rd_done <= 1'b0;
            obj_rd_done <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    // Writes first
                    if (!fifo_empty) begin
                        state     <= SEQ_WRITE;
                        sdram_req <= 1'b1;
                        sdram_we  <= 1'b1;
                    end else if (rd_allow && (scr_rd_req || obj_rd_req)) begin
                        state     <= SEQ_READ_ACK;
                        sdram_req <= 1'b1;
                        sdram_we  <= 1'b0;
                        last_obj  <= pick_obj;
                    end
                end
                SEQ_WRITE: begin
                    if (sdram_ack) begin
                        state     <= SEQ_IDLE;
                        sdram_req <= 1'b0;
                        sdram_we  <= 1'b0;
                    end
                end
                SEQ_READ_ACK: begin
                    if (sdram_ack) begin
                        state     <= SEQ_READ_DATA;
                        sdram_req <= 1'b0;
                    end
                end
                SEQ_READ_DATA: begin
                    if (data_rdy) begin
                        state       <= SEQ_IDLE;
                        scr_rd_done <= !last_obj;
                        obj_rd_done <= last_obj;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    // Request payload, only loaded in idle
    always_ff @(posedge clk) begin
        if (state == SEQ_IDLE) begin
            if (!fifo_empty) begin
                sdram_addr <= fifo_addr;
                sdram_din  <= fifo_data;
                sdram_mask <= fifo_mask;
            end else begin
                sdram_addr <= pick_obj ? obj_rd_addr : scr_rd_addr;
                sdram_mask <= 2'b00;
            end
        end
        if (state == SEQ_READ_DATA && data_rdy) begin
            rd_data <= data_read;
        end
    end

    a_req_hold: assert property (
        @(posedge clk) disable iff (!arst_n)
        sdram_req && !sdram_ack |=> sdram_req && $stable(sdram_addr) && $stable(sdram_we)
    ) else $error("SDRAM request changed before ack");

endmodule

`default_nettype wire

// File: source/rom_slot.sv
/* Cached ROM read slot, one word deep, with region offset */
`timescale 1ns/100ps
`default_nettype none

module rom_slot
    import kicker_rom_pkg::*;
#(
    parameter int          AW     = 13,
    parameter sdram_addr_t OFFSET = '0
) (
    input  wire logic          clk,
    input  wire logic          arst_n,
    input  wire logic          cs,
    input  wire logic [AW-1:0] addr,
    output logic               ok,
    output word_t              dout,
    output logic               rd_req,
    output sdram_addr_t        rd_addr,
    input  wire logic          rd_done,
    input  wire word_t         rd_data
);

    logic [AW-1:0] cached_addr;
    logic [AW-1:0] pend_addr;
    logic          valid;
    logic          hit;
    logic          start;

    assign hit   = valid && cached_addr == addr;
    assign ok    = cs && hit;
    // New fetch only when nothing is outstanding
    assign start = cs && !hit && !rd_req;

    assign rd_addr = OFFSET + sdram_addr_t'(pend_addr);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_req <= 1'b0;
            valid  <= 1'b0;
        end else if (rd_done) begin
            rd_req <= 1'b0;
            valid  <= 1'b1;
        end else if (start) begin
            rd_req <= 1'b1;
        end
    end

    // Cache line and the address being fetched
    always_ff @(posedge clk) begin
        if (rd_done) begin
            cached_addr <= pend_addr;
            dout        <= rd_data;
        end else if (start) begin
            pend_addr <= addr;
        end
    end

    // Sequencer must route each done to the slot that asked
    a_done_owned: assert property (
        @(posedge clk) disable iff (!arst_n)
        rd_done |-> rd_req
    ) else $error("Read done without an outstanding request");

endmodule

`default_nettype wire

// File: source/kicker_rom_top.sv
/* ROM path top: download translator, write FIFO,
   SDRAM sequencer and the scroll and object slots */
`timescale 1ns/100ps
`default_nettype none
`include "kicker_rom_consts.svh"

module kicker_rom_top
    import kicker_rom_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               arst_n,
    // Loader
    input  wire logic               downloading,
    input  wire ioctl_addr_t        ioctl_addr,
    input  wire byte_t              ioctl_dout,
    input  wire logic               ioctl_wr,
    output prom_addr_t              prom_addr,
    output byte_t                   prom_data,
    output logic                    prom_we,
    output logic                    dwnld_busy,
    // Scroll and object ROM reads
    input  wire logic               scr_cs,
    input  wire logic [`SCR_AW-1:0] scr_addr,
    output logic                    scr_ok,
    output word_t                   scr_data,
    input  wire logic               obj_cs,
    input  wire logic [`OBJ_AW-1:0] obj_addr,
    output logic                    obj_ok,
    output word_t                   obj_data,
    // SDRAM
    output logic                    sdram_req,
    output logic                    sdram_we,
    output sdram_addr_t             sdram_addr,
    output word_t                   sdram_din,
    output logic [1:0]              sdram_mask,
    input  wire logic               sdram_ack,
    input  wire logic               data_rdy,
    input  wire word_t              data_read
);

    // Slot offsets in SDRAM words
    localparam sdram_addr_t SCR_OFFSET = sdram_addr_t'(`SCR_START >> 1);
    localparam sdram_addr_t OBJ_OFFSET = sdram_addr_t'(`OBJ_START >> 1);

    sdram_addr_t prog_addr;
    word_t       prog_data;
    logic [1:0]  prog_mask;
    logic        push;

    logic        fifo_empty;
    sdram_addr_t fifo_addr;
    word_t       fifo_data;
    logic [1:0]  fifo_mask;
    logic        fifo_pop;

    logic        scr_rd_req;
    sdram_addr_t scr_rd_addr;
    logic        scr_rd_done;
    logic        obj_rd_req;
    sdram_addr_t obj_rd_addr;
    logic        obj_rd_done;
    word_t       rd_data;

    rom_dwnld u_dwnld (
        .clk        (clk),
        .arst_n     (arst_n),
        .ioctl_addr (ioctl_addr),
        .ioctl_dout (ioctl_dout),
        .ioctl_wr   (ioctl_wr),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .prog_mask  (prog_mask),
        .push       (push),
        .prom_addr  (prom_addr),
        .prom_data  (prom_data),
        .prom_we    (prom_we)
    );

    prog_fifo #(
        .DEPTH (`PROG_FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (push),
        .din_addr  (prog_addr),
        .din_data  (prog_data),
        .din_mask  (prog_mask),
        .pop       (fifo_pop),
        .empty     (fifo_empty),
        .dout_addr (fifo_addr),
        .dout_data (fifo_data),
        .dout_mask (fifo_mask)
    );

    sdram_sequencer u_seq (
        .clk         (clk),
        .arst_n      (arst_n),
        .downloading (downloading),
        .fifo_empty  (fifo_empty),
        .fifo_addr   (fifo_addr),
        .fifo_data   (fifo_data),
        .fifo_mask   (fifo_mask),
        .fifo_pop    (fifo_pop),
        .scr_rd_req  (scr_rd_req),
        .scr_rd_addr (scr_rd_addr),
        .obj_rd_req  (obj_rd_req),
        .obj_rd_addr (obj_rd_addr),
        .scr_rd_done (scr_rd_done),
        .obj_rd_done (obj_rd_done),
        .rd_data     (rd_data),
        .sdram_req   (sdram_req),
        .sdram_we    (sdram_we),
        .sdram_addr  (sdram_addr),
        .sdram_din   (sdram_din),
        .sdram_mask  (sdram_mask),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read),
        .dwnld_busy  (dwnld_busy)
    );

    rom_slot #(
        .AW     (`SCR_AW),
        .OFFSET (SCR_OFFSET)
    ) u_scr (
        .clk     (clk),
        .arst_n  (arst_n),
        .cs      (scr_cs),
        .addr    (scr_addr),
        .ok      (scr_ok),
        .dout    (scr_data),
        .rd_req  (scr_rd_req),
        .rd_addr (scr_rd_addr),
        .rd_done (scr_rd_done),
        .rd_data (rd_data)
    );

    rom_slot #(
        .AW     (`OBJ_AW),
        .OFFSET (OBJ_OFFSET)
    ) u_obj (
        .clk     (clk),
        .arst_n  (arst_n),
        .cs      (obj_cs),
        .addr    (obj_addr),
        .ok      (obj_ok),
        .dout    (obj_data),
        .rd_req  (obj_rd_req),
        .rd_addr (obj_rd_addr),
        .rd_done (obj_rd_done),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// File: verification/sdram_model.sv
/* Behavioral SDRAM: delayed ack, byte-masked writes, read data two cycles after ack */
`timescale 1ns/100ps
`default_nettype none

module sdram_model
    import kicker_rom_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic [1:0]  ack_delay,
    input  wire logic        sdram_req,
    input  wire logic        sdram_we,
    input  wire sdram_addr_t sdram_addr,
    input  wire word_t       sdram_din,
    input  wire logic [1:0]  sdram_mask,
    output logic             sdram_ack,
    output logic             data_rdy,
    output word_t            data_read
);

    word_t       mem [sdram_addr_t];
    logic        busy;
    logic [1:0]  wait_cnt;
    logic [1:0]  rd_cnt;
    sdram_addr_t rd_addr;

    // Unwritten words read back a pattern of their full address
    function automatic word_t read_word(input sdram_addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a[15:0] ^ {10'h2a5, a[21:16]};
    endfunction

    always @(posedge clk or negedge arst_n) begin : model_seq
        word_t merged;
        if (!arst_n) begin
            busy      <= 1'b0;
            wait_cnt  <= 2'd0;
            rd_cnt    <= 2'd0;
            rd_addr   <= '0;
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            data_read <= '0;
        end else begin
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            if (rd_cnt == 2'd1) begin
                data_rdy  <= 1'b1;
                data_read <= read_word(rd_addr);
            end
            if (rd_cnt != 2'd0) begin
                rd_cnt <= rd_cnt - 2'd1;
            end
            if (sdram_ack) begin
                busy <= 1'b0;
                if (sdram_we) begin
                    // Active-low mask, a cleared bit writes that byte lane
                    merged = read_word(sdram_addr);
                    if (!sdram_mask[0]) begin
                        merged[7:0] = sdram_din[7:0];
                    end
                    if (!sdram_mask[1]) begin
                        merged[15:8] = sdram_din[15:8];
                    end
                    mem[sdram_addr] = merged;
                end else begin
                    rd_cnt  <= 2'd2;
                    rd_addr <= sdram_addr;
                end
            end else if (sdram_req && !busy) begin
                busy     <= 1'b1;
                wait_cnt <= ack_delay;
            end else if (busy) begin
                if (wait_cnt <= 2'd1) begin
                    sdram_ack <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/kicker_rom_tb.sv
/* ROM path testbench: reset, download, swizzle, PROM routing and slot read tests
   with a byte-level model of the region swizzle */
`timescale 1ns/100ps
`default_nettype none
`include "kicker_rom_consts.svh"

module kicker_rom_tb
    import kicker_rom_pkg::*;
();

    localparam int N_MAIN = 8;
    localparam int N_SCR  = 8;
    localparam int N_OBJ  = 32;
    localparam int N_PROM = 6;
    localparam int WATCHDOG_CYCLES = (N_MAIN + N_SCR + N_OBJ + N_PROM) * 200 + 1000;
    localparam logic [31:0] SEED = 32'hba820d7d;

    logic                clk;
    logic                arst_n;
    logic                downloading;
    ioctl_addr_t         ioctl_addr;
    byte_t               ioctl_dout;
    logic                ioctl_wr;
    prom_addr_t          prom_addr;
    byte_t               prom_data;
    logic                prom_we;
    logic                dwnld_busy;
    logic                scr_cs;
    logic [`SCR_AW-1:0]  scr_addr;
    logic                scr_ok;
    word_t               scr_data;
    logic                obj_cs;
    logic [`OBJ_AW-1:0]  obj_addr;
    logic                obj_ok;
    word_t               obj_data;
    logic                sdram_req;
    logic                sdram_we;
    sdram_addr_t         sdram_addr;
    word_t               sdram_din;
    logic [1:0]          sdram_mask;
    logic                sdram_ack;
    logic                data_rdy;
    word_t               data_read;
    logic [1:0]          ack_delay;

    int          errors;
    int          checks;
    int          ack_count;
    int          write_count;
    logic [31:0] data_rng;
    logic [31:0] delay_rng;

    // Expected SDRAM image by swizzled byte address
    byte_t       exp_mem [logic [22:0]];
    sdram_addr_t exp_addr_q [$];
    word_t       exp_data_q [$];
    logic [1:0]  exp_mask_q [$];
    sdram_addr_t wr_addr_q [$];
    word_t       wr_data_q [$];
    logic [1:0]  wr_mask_q [$];
    prom_addr_t  exp_prom_addr_q [$];
    byte_t       exp_prom_data_q [$];
    prom_addr_t  prom_addr_q [$];
    byte_t       prom_data_q [$];

    kicker_rom_top uut (.*);

    sdram_model u_sdram (.*);

    always #20 clk = ~clk;

    // Ack delay stream independent of the stimulus stream
    always @(posedge clk) begin
        #5;
        delay_rng = xorshift32(delay_rng);
        ack_delay = 2'(delay_rng % 3) + 2'd1;
    end

    // Bus monitor samples mid-cycle when everything is settled
    always @(negedge clk) begin
        if (sdram_req && sdram_ack) begin
            ack_count = ack_count + 1;
            if (sdram_we) begin
                write_count = write_count + 1;
                wr_addr_q.push_back(sdram_addr);
                wr_data_q.push_back(sdram_din);
                wr_mask_q.push_back(sdram_mask);
            end
        end
        if (prom_we) begin
            prom_addr_q.push_back(prom_addr);
            prom_data_q.push_back(prom_data);
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        data_rng = xorshift32(data_rng);
        return data_rng;
    endfunction

    // Scroll flips bit 0 and object reorders the low five bits
    function automatic logic [22:0] expected_byte_addr(input ioctl_addr_t a);
        logic [22:0] r;
        r = a[22:0];
        if (a >= `SCR_START && a < `OBJ_START) begin
            r[0] = ~a[0];
        end else if (a >= `OBJ_START && a < `PCM_START) begin
            r[4] = a[2];
            r[3] = a[1];
            r[2] = a[0];
            r[1] = ~a[4];
            r[0] = ~a[3];
        end
        return r;
    endfunction

    function automatic word_t expected_word(input logic [22:0] b);
        return {exp_mem[b + 23'd1], exp_mem[b]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name, input int start_err);
        $display("Test %s finished with %0d errors", name, errors - start_err);
    endtask

    task automatic write_byte(input ioctl_addr_t a, input byte_t d);
        logic [22:0] b;
        if (a >= `PROM_START) begin
            exp_prom_addr_q.push_back(prom_addr_t'(a - `PROM_START));
            exp_prom_data_q.push_back(d);
        end else begin
            b = expected_byte_addr(a);
            exp_mem[b] = d;
            exp_addr_q.push_back(b[22:1]);
            exp_data_q.push_back({d, d});
            exp_mask_q.push_back(b[0] ? 2'b01 : 2'b10);
        end
        @(posedge clk);
        #5;
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(posedge clk);
        #5;
        ioctl_wr = 1'b0;
        repeat (3) @(posedge clk);
    endtask

    task automatic start_download();
        @(posedge clk);
        #5;
        downloading = 1'b1;
    endtask

    task automatic finish_download();
        int n;
        @(posedge clk);
        #5;
        downloading = 1'b0;
        n = 0;
        @(negedge clk);
        while (dwnld_busy && n < 500) begin
            @(negedge clk);
            n = n + 1;
        end
        if (dwnld_busy) begin
            errors = errors + 1;
            $display("Error at %0t: dwnld_busy stayed high after the download", $time);
        end
        @(posedge clk);
    endtask

    task automatic compare_writes();
        check_value("sdram write count", wr_addr_q.size(), exp_addr_q.size());
        while (wr_addr_q.size() > 0 && exp_addr_q.size() > 0) begin
            check_value("sdram_addr", wr_addr_q.pop_front(), exp_addr_q.pop_front());
            check_value("sdram_din", wr_data_q.pop_front(), exp_data_q.pop_front());
            check_value("sdram_mask", wr_mask_q.pop_front(), exp_mask_q.pop_front());
        end
        wr_addr_q.delete();
        wr_data_q.delete();
        wr_mask_q.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
        exp_mask_q.delete();
    endtask

    task automatic read_slot(input logic is_obj, input int addr);
        int          n;
        logic [22:0] base;
        word_t       exp;
        base = is_obj ? 23'(`OBJ_START) : 23'(`SCR_START);
        exp  = expected_word(base + 23'(addr * 2));
        @(posedge clk);
        #5;
        if (is_obj) begin
            obj_cs   = 1'b1;
            obj_addr = `OBJ_AW'(addr);
        end else begin
            scr_cs   = 1'b1;
            scr_addr = `SCR_AW'(addr);
        end
        n = 0;
        @(negedge clk);
        while (!(is_obj ? obj_ok : scr_ok) && n < 100) begin
            @(negedge clk);
            n = n + 1;
        end
        if (is_obj ? obj_ok : scr_ok) begin
            check_value(is_obj ? "obj_data" : "scr_data", is_obj ? obj_data : scr_data, exp);
        end else begin
            errors = errors + 1;
            $display("Error at %0t: read of slot word %0d never completed", $time, addr);
        end
        @(posedge clk);
        #5;
        scr_cs = 1'b0;
        obj_cs = 1'b0;
    endtask

    task automatic test_reset();
        int start_err;
        start_err = errors;
        @(negedge clk);
        check_value("sdram_req", sdram_req, 1'b0);
        check_value("sdram_we", sdram_we, 1'b0);
        check_value("prom_we", prom_we, 1'b0);
        check_value("scr_ok", scr_ok, 1'b0);
        check_value("obj_ok", obj_ok, 1'b0);
        check_value("dwnld_busy", dwnld_busy, 1'b0);
        report_test("reset", start_err);
    endtask

    task automatic test_main_download();
        int start_err;
        int i;
        start_err = errors;
        start_download();
        @(negedge clk);
        check_value("dwnld_busy", dwnld_busy, 1'b1);
        for (i = 0; i < N_MAIN; i++) begin
            write_byte(ioctl_addr_t'(next_rand() % `SCR_START), byte_t'(next_rand()));
        end
        finish_download();
        compare_writes();
        report_test("main_download", start_err);
    endtask

    task automatic test_swizzle();
        int start_err;
        int i;
        start_err = errors;
        start_download();
        for (i = 0; i < N_SCR; i++) begin
            write_byte(ioctl_addr_t'(`SCR_START + i), byte_t'(next_rand()));
        end
        // One full 32-byte block so every object word is complete
        for (i = 0; i < N_OBJ; i++) begin
            write_byte(ioctl_addr_t'(`OBJ_START + i), byte_t'(next_rand()));
        end
        finish_download();
        compare_writes();
        report_test("swizzle", start_err);
    endtask

    task automatic test_prom();
        int start_err;
        int writes_before;
        int i;
        start_err     = errors;
        writes_before = write_count;
        start_download();
        for (i = 0; i < N_PROM; i++) begin
            write_byte(`PROM_START + ioctl_addr_t'(next_rand() % 2048), byte_t'(next_rand()));
        end
        finish_download();
        check_value("sdram writes for PROM bytes", write_count, writes_before);
        check_value("prom write count", prom_addr_q.size(), exp_prom_addr_q.size());
        while (prom_addr_q.size() > 0 && exp_prom_addr_q.size() > 0) begin
            check_value("prom_addr", prom_addr_q.pop_front(), exp_prom_addr_q.pop_front());
            check_value("prom_data", prom_data_q.pop_front(), exp_prom_data_q.pop_front());
        end
        report_test("prom", start_err);
    endtask

    task automatic test_slot_reads();
        int   start_err;
        int   acks;
        int   n;
        logic req_seen;
        start_err = errors;
        read_slot(1'b0, 2);
        read_slot(1'b1, 5);
        // Same scroll word again is served from the slot cache
        @(posedge clk);
        #5;
        acks     = ack_count;
        scr_cs   = 1'b1;
        scr_addr = `SCR_AW'(2);
        @(negedge clk);
        check_value("scr_ok", scr_ok, 1'b1);
        check_value("scr_data", scr_data, expected_word(23'(`SCR_START) + 23'd4));
        req_seen = sdram_req;
        // Long enough for a stray fetch to reach the SDRAM port and be acked
        repeat (8) begin
            @(negedge clk);
            if (sdram_req) begin
                req_seen = 1'b1;
            end
        end
        check_value("sdram_req on hit", req_seen, 1'b0);
        check_value("sdram transactions on hit", ack_count, acks);
        @(posedge clk);
        #5;
        scr_cs = 1'b0;
        // Both slots miss in the same cycle
        @(posedge clk);
        #5;
        scr_cs   = 1'b1;
        scr_addr = `SCR_AW'(1);
        obj_cs   = 1'b1;
        obj_addr = `OBJ_AW'(9);
        n = 0;
        @(negedge clk);
        while (!(scr_ok && obj_ok) && n < 200) begin
            @(negedge clk);
            n = n + 1;
        end
        if (scr_ok && obj_ok) begin
            check_value("scr_data", scr_data, expected_word(23'(`SCR_START) + 23'd2));
            check_value("obj_data", obj_data, expected_word(23'(`OBJ_START) + 23'd18));
        end else begin
            errors = errors + 1;
            $display("Error at %0t: concurrent slot reads did not both complete", $time);
        end
        @(posedge clk);
        #5;
        scr_cs = 1'b0;
        obj_cs = 1'b0;
        report_test("slot_reads", start_err);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        scr_cs      = 1'b0;
        scr_addr    = '0;
        obj_cs      = 1'b0;
        obj_addr    = '0;
        ack_delay   = 2'd1;
        errors      = 0;
        checks      = 0;
        ack_count   = 0;
        write_count = 0;
        data_rng    = SEED;
        delay_rng   = ~SEED;
        repeat (5) @(posedge clk);
        #5;
        arst_n = 1'b1;
        test_reset();
        test_main_download();
        test_swizzle();
        test_prom();
        test_slot_reads();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: kicker_rom.f
+incdir+source
source/kicker_rom_pkg.sv
source/rom_dwnld.sv
source/prog_fifo.sv
source/sdram_sequencer.sv
source/rom_slot.sv
source/kicker_rom_top.sv
verification/sdram_model.sv
verification/kicker_rom_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the ROM path testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f kicker_rom.f \
    --top-module kicker_rom_tb -o kicker_rom_sim \
    && ./obj_dir/kicker_rom_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0
